// ==== Bender.yml ====
package:
  name: pipe_core

sources:
  - source/pipe_pkg.sv
  - source/inst_decoder.sv
  - source/reg_file.sv
  - source/id_ex_buffer.sv
  - source/exec_unit.sv
  - source/pipe_control.sv
  - source/pipe_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/pipe_core_tb.sv

// ==== pipe_core.f ====
+incdir+tests
source/pipe_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/id_ex_buffer.sv
source/exec_unit.sv
source/pipe_control.sv
source/pipe_core.sv
tests/pipe_core_tb.sv

// ==== source/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit (
	input logic clk,
	input logic rst,
	input pipe_pkg::id_ex_t ex_in,
	output logic [pipe_pkg::xlen-1:0] ex_result,
	output logic br_taken,
	output logic [pipe_pkg::xlen-1:0] br_target,
	output pipe_pkg::retire_t retire
);

	logic [pipe_pkg::xlen-1:0] op_a;
	logic [pipe_pkg::xlen-1:0] op_b;
	logic [pipe_pkg::shamt_w-1:0] shamt;
	logic lt;
	logic eq;
	logic cond;

	assign op_a = ex_in.rs1_val;
	assign op_b = ex_in.dec.oper2_immed ? ex_in.dec.imm : ex_in.rs2_val;
	assign shamt = op_b[pipe_pkg::shamt_w-1:0];
	assign lt = $signed(op_a) < $signed(op_b);
	assign eq = op_a == op_b;

	always_comb begin
		case (ex_in.dec.alu_op)
		pipe_pkg::alu_add: ex_result = op_a + op_b;
		pipe_pkg::alu_sub: ex_result = op_a - op_b;
		pipe_pkg::alu_and: ex_result = op_a & op_b;
		pipe_pkg::alu_or: ex_result = op_a | op_b;
		pipe_pkg::alu_xor: ex_result = op_a ^ op_b;
		pipe_pkg::alu_slt: ex_result = {{(pipe_pkg::xlen-1){1'b0}}, lt};
		pipe_pkg::alu_sll: ex_result = op_a << shamt;
		pipe_pkg::alu_srl: ex_result = op_a >> shamt;
		pipe_pkg::alu_pass_b: ex_result = op_b; // lui.
		default: ex_result = '0;
		endcase
	end

	// branches never use the immediate as operand B, so op_b is rs2 here.
	always_comb begin
		case (ex_in.dec.br)
		pipe_pkg::br_eq: cond = eq;
		pipe_pkg::br_ne: cond = !eq;
		pipe_pkg::br_lt: cond = lt;
		pipe_pkg::br_le: cond = lt || eq;
		pipe_pkg::br_gt: cond = !lt && !eq;
		pipe_pkg::br_ge: cond = !lt;
		default: cond = 1'b0;
		endcase
	end

	assign br_taken = ex_in.valid && (ex_in.dec.kind == pipe_pkg::op_branch) && cond;
	assign br_target = ex_in.pc + ex_in.dec.imm;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			retire <= '0;
		end else begin
			retire.valid <= ex_in.valid;
			retire.pc <= ex_in.pc;
			retire.rd <= ex_in.dec.rd;
			retire.reg_write <= ex_in.dec.reg_write;
			retire.taken <= br_taken;
			// a branch reports its fall-through address instead of an ALU value.
			if (ex_in.dec.kind == pipe_pkg::op_branch)
				retire.value <= ex_in.pfc;
			else
				retire.value <= ex_result;
		end
	end

endmodule

// ==== source/id_ex_buffer.sv ====
`timescale 1ns/10ps

module id_ex_buffer (
	input logic clk,
	input logic rst,
	input logic flush,
	input pipe_pkg::id_ex_t id_in,
	output pipe_pkg::id_ex_t ex_out
);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_out <= '0;
		end else if (flush) begin
			ex_out <= '0; // wrong-path word becomes a bubble.
		end else begin
			ex_out <= id_in;
			ex_out.pfc <= id_in.pc + pipe_pkg::xlen'(1); // pc counts words.
		end
	end

	// the bubble left by a flush can never redirect fetch again.
	flush_not_repeated: assert property (
		@(posedge clk) disable iff (rst) flush |=> !flush
	);

endmodule

// ==== source/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder (
	input logic [pipe_pkg::xlen-1:0] inst,
	output pipe_pkg::dec_t dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic bad; // word is not one of the supported encodings.

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		dec = '0;
		bad = 1'b0;
		dec.kind = pipe_pkg::op_illegal;
		dec.alu_op = pipe_pkg::alu_add;
		dec.br = pipe_pkg::br_none;
		dec.rs1 = inst[19:15];
		dec.rs2 = inst[24:20];
		dec.rd = inst[11:7];

		case (opcode)
		pipe_pkg::opc_reg: begin
			dec.kind = pipe_pkg::op_alu_r;
			dec.reg_write = 1'b1;
			case (funct3)
			3'b000: dec.alu_op = (funct7 == pipe_pkg::f7_alt) ? pipe_pkg::alu_sub
				: pipe_pkg::alu_add;
			3'b001: dec.alu_op = pipe_pkg::alu_sll;
			3'b010: dec.alu_op = pipe_pkg::alu_slt;
			3'b100: dec.alu_op = pipe_pkg::alu_xor;
			3'b101: dec.alu_op = pipe_pkg::alu_srl;
			3'b110: dec.alu_op = pipe_pkg::alu_or;
			3'b111: dec.alu_op = pipe_pkg::alu_and;
			default: bad = 1'b1; // sltu is not supported.
			endcase
			// only sub may carry the alternate funct7.
			if (funct7 != pipe_pkg::f7_base && !(funct3 == 3'b000 && funct7 == pipe_pkg::f7_alt))
				bad = 1'b1;
		end
		pipe_pkg::opc_imm: begin
			dec.kind = pipe_pkg::op_alu_i;
			dec.reg_write = 1'b1;
			dec.oper2_immed = 1'b1;
			dec.imm = {{(pipe_pkg::xlen-12){inst[31]}}, inst[31:20]};
			case (funct3)
			3'b000: dec.alu_op = pipe_pkg::alu_add;
			3'b010: dec.alu_op = pipe_pkg::alu_slt;
			3'b100: dec.alu_op = pipe_pkg::alu_xor;
			3'b110: dec.alu_op = pipe_pkg::alu_or;
			3'b111: dec.alu_op = pipe_pkg::alu_and;
			default: bad = 1'b1; // immediate shifts and sltiu are left out.
			endcase
		end
		pipe_pkg::opc_lui: begin
			dec.kind = pipe_pkg::op_lui;
			dec.alu_op = pipe_pkg::alu_pass_b;
			dec.reg_write = 1'b1;
			dec.oper2_immed = 1'b1;
			dec.imm = {inst[31:12], 12'b0};
		end
		pipe_pkg::opc_branch: begin
			dec.kind = pipe_pkg::op_branch;
			// the B field is taken as a signed word offset, without the usual low zero.
			dec.imm = {{(pipe_pkg::xlen-12){inst[31]}}, inst[31], inst[7], inst[30:25],
				inst[11:8]};
			case (funct3)
			3'b000: dec.br = pipe_pkg::br_eq;
			3'b001: dec.br = pipe_pkg::br_ne;
			3'b100: dec.br = pipe_pkg::br_lt;
			3'b101: dec.br = pipe_pkg::br_ge;
			3'b110: dec.br = pipe_pkg::br_le; // ble and bgt reuse the unsigned slots.
			3'b111: dec.br = pipe_pkg::br_gt;
			default: bad = 1'b1;
			endcase
		end
		default: bad = 1'b1;
		endcase

		if (bad) begin
			dec.kind = pipe_pkg::op_illegal;
			dec.br = pipe_pkg::br_none;
			dec.reg_write = 1'b0; // retires as a bubble with no write.
		end
	end

endmodule

// ==== source/pipe_control.sv ====
`timescale 1ns/10ps

module pipe_control (
	input logic clk,
	input logic rst,
	input logic [pipe_pkg::reg_idx_w-1:0] dec_rs1,
	input logic [pipe_pkg::reg_idx_w-1:0] dec_rs2,
	input pipe_pkg::id_ex_t ex_entry,
	input logic br_taken,
	input logic [pipe_pkg::xlen-1:0] br_target,
	output logic [pipe_pkg::xlen-1:0] fetch_pc,
	output logic flush,
	output pipe_pkg::fwd_sel_e fwd_a,
	output pipe_pkg::fwd_sel_e fwd_b
);

	logic [pipe_pkg::xlen-1:0] next_pc;
	logic ex_is_branch;
	logic ex_writes; // EX entry will produce a register value.

	assign ex_is_branch = ex_entry.valid && (ex_entry.dec.kind == pipe_pkg::op_branch);

	// mispredict when the resolved direction differs from the guess.
	assign flush = ex_is_branch && (br_taken != ex_entry.predicted);
	assign next_pc = flush ? br_target : fetch_pc + pipe_pkg::xlen'(1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			fetch_pc <= '0;
		else
			fetch_pc <= next_pc;
	end

	assign ex_writes = ex_entry.valid && ex_entry.dec.reg_write && (ex_entry.dec.rd != '0);

	// older results sitting in writeback are covered by the register file bypass.
	always_comb begin
		fwd_a = pipe_pkg::fwd_rf;
		fwd_b = pipe_pkg::fwd_rf;
		if (ex_writes && ex_entry.dec.rd == dec_rs1)
			fwd_a = pipe_pkg::fwd_ex;
		if (ex_writes && ex_entry.dec.rd == dec_rs2)
			fwd_b = pipe_pkg::fwd_ex;
	end

	// a taken result may only come from a live branch in EX.
	taken_needs_live_branch: assert property (
		@(posedge clk) disable iff (rst) br_taken |-> ex_is_branch
	);

endmodule

// ==== source/pipe_core.sv ====
`timescale 1ns/10ps

module pipe_core (
	input logic clk,
	input logic rst,
	output logic [pipe_pkg::xlen-1:0] fetch_pc,
	input logic [pipe_pkg::xlen-1:0] fetch_inst,
	output pipe_pkg::retire_t retire
);

	pipe_pkg::dec_t dec;
	pipe_pkg::id_ex_t id_in;
	pipe_pkg::id_ex_t ex_entry;
	pipe_pkg::fwd_sel_e fwd_a;
	pipe_pkg::fwd_sel_e fwd_b;
	logic [pipe_pkg::xlen-1:0] rf_a;
	logic [pipe_pkg::xlen-1:0] rf_b;
	logic [pipe_pkg::xlen-1:0] ex_result;
	logic [pipe_pkg::xlen-1:0] br_target;
	logic br_taken;
	logic flush;

	pipe_control i_control (
		.clk(clk),
		.rst(rst),
		.dec_rs1(dec.rs1),
		.dec_rs2(dec.rs2),
		.ex_entry(ex_entry),
		.br_taken(br_taken),
		.br_target(br_target),
		.fetch_pc(fetch_pc),
		.flush(flush),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	inst_decoder i_decoder (.inst(fetch_inst), .dec(dec));

	reg_file i_regs (
		.clk(clk),
		.rst(rst),
		.rs1_idx(dec.rs1),
		.rs2_idx(dec.rs2),
		.rs1_val(rf_a),
		.rs2_val(rf_b),
		.wb(retire)
	);

	// stage 1 payload; pfc is filled in by the buffer.
	assign id_in = '{
		valid: 1'b1,
		pc: fetch_pc,
		pfc: '0,
		inst: fetch_inst,
		dec: dec,
		rs1_val: (fwd_a == pipe_pkg::fwd_ex) ? ex_result : rf_a,
		rs2_val: (fwd_b == pipe_pkg::fwd_ex) ? ex_result : rf_b,
		predicted: 1'b0
	};

	id_ex_buffer i_id_ex (.clk(clk), .rst(rst), .flush(flush), .id_in(id_in), .ex_out(ex_entry));

	exec_unit i_exec (
		.clk(clk),
		.rst(rst),
		.ex_in(ex_entry),
		.ex_result(ex_result),
		.br_taken(br_taken),
		.br_target(br_target),
		.retire(retire)
	);

endmodule

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

	localparam int xlen = 32;
	localparam int reg_idx_w = 5;
	localparam int num_regs = 32;
	localparam int shamt_w = 5; // shifts only look at the low five bits.

	// major opcodes of the supported instruction classes.
	localparam logic [6:0] opc_reg = 7'b0110011;
	localparam logic [6:0] opc_imm = 7'b0010011;
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_branch = 7'b1100011;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt = 7'b0100000; // selects sub.

	typedef enum logic [2:0] {
		op_alu_r,
		op_alu_i,
		op_lui,
		op_branch,
		op_illegal
	} op_kind_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl,
		alu_pass_b
	} alu_op_e;

	// all branch comparisons are signed.
	typedef enum logic [2:0] {
		br_none,
		br_eq,
		br_ne,
		br_lt,
		br_le,
		br_gt,
		br_ge
	} br_kind_e;

	typedef enum logic {
		fwd_rf,
		fwd_ex
	} fwd_sel_e;

	typedef struct packed {
		op_kind_e kind;
		alu_op_e alu_op;
		br_kind_e br;
		logic [reg_idx_w-1:0] rs1;
		logic [reg_idx_w-1:0] rs2;
		logic [reg_idx_w-1:0] rd;
		logic [xlen-1:0] imm;
		logic oper2_immed;
		logic reg_write;
	} dec_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] pfc;
		logic [xlen-1:0] inst;
		dec_t dec;
		logic [xlen-1:0] rs1_val;
		logic [xlen-1:0] rs2_val;
		logic predicted; // static not-taken prediction.
	} id_ex_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] pc;
		logic [reg_idx_w-1:0] rd;
		logic reg_write;
		logic [xlen-1:0] value;
		logic taken;
	} retire_t;

endpackage

// ==== source/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
	input logic clk,
	input logic rst,
	input logic [pipe_pkg::reg_idx_w-1:0] rs1_idx,
	input logic [pipe_pkg::reg_idx_w-1:0] rs2_idx,
	output logic [pipe_pkg::xlen-1:0] rs1_val,
	output logic [pipe_pkg::xlen-1:0] rs2_val,
	input pipe_pkg::retire_t wb
);

	logic [pipe_pkg::xlen-1:0] regs [pipe_pkg::num_regs];
	logic wb_en;

	assign wb_en = wb.valid && wb.reg_write && (wb.rd != '0); // x0 is never written.

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < pipe_pkg::num_regs; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[wb.rd] <= wb.value;
		end
	end

	// a value being written this cycle is seen by a read in the same cycle.
	always_comb begin
		if (rs1_idx == '0)
			rs1_val = '0;
		else if (wb_en && wb.rd == rs1_idx)
			rs1_val = wb.value;
		else
			rs1_val = regs[rs1_idx];

		if (rs2_idx == '0)
			rs2_val = '0;
		else if (wb_en && wb.rd == rs2_idx)
			rs2_val = wb.value;
		else
			rs2_val = regs[rs2_idx];
	end

	// a retired write always carries a known value.
	write_value_known: assert property (
		@(posedge clk) disable iff (rst) wb_en |-> !$isunknown(wb.value)
	);

endmodule

// ==== tests/ref_model.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

typedef struct packed {
	pipe_pkg::retire_t rec;
	logic value_known; // illegal words leave the value undefined.
} expect_t;

logic [pipe_pkg::xlen-1:0] rom [256];
int prog_len;
integer seed;
logic [pipe_pkg::xlen-1:0] shadow_regs [32];
expect_t expected [$];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
	return {f7, rs2, rs1, f3, rd, pipe_pkg::opc_reg};
endfunction

function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, pipe_pkg::opc_imm};
endfunction

// branch offsets count words and are split like the B format.
function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] off);
	return {off[11], off[9:4], rs2, rs1, f3, off[3:0], off[10], pipe_pkg::opc_branch};
endfunction

function automatic logic alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b, output logic [31:0] res);
	alu_ref = 1'b1;
	case (f3)
	3'b000: res = alt ? a - b : a + b;
	3'b001: res = a << b[4:0];
	3'b010: res = {31'b0, $signed(a) < $signed(b)};
	3'b100: res = a ^ b;
	3'b101: res = a >> b[4:0];
	3'b110: res = a | b;
	3'b111: res = a & b;
	default: begin
		res = '0;
		alu_ref = 1'b0;
	end
	endcase
endfunction

// executes one instruction on the shadow registers and returns its retire record.
function automatic void ref_step(input logic [31:0] inst, input logic [31:0] pc,
		output expect_t e, output logic [31:0] next_pc);
	logic [2:0] f3;
	logic [6:0] f7;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] res;
	logic ok;
	logic taken;
	f3 = inst[14:12];
	f7 = inst[31:25];
	a = shadow_regs[inst[19:15]];
	b = shadow_regs[inst[24:20]];
	res = '0;
	ok = 1'b0;
	taken = 1'b0;
	case (inst[6:0])
	pipe_pkg::opc_reg: begin
		ok = alu_ref(f3, f7[5], a, b, res);
		ok = ok && (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000));
	end
	pipe_pkg::opc_imm: begin
		ok = alu_ref(f3, 1'b0, a, {{20{inst[31]}}, inst[31:20]}, res);
		ok = ok && f3 != 3'b001 && f3 != 3'b101; // no immediate shifts.
	end
	pipe_pkg::opc_lui: begin
		ok = 1'b1;
		res = {inst[31:12], 12'b0};
	end
	pipe_pkg::opc_branch: begin
		ok = f3 != 3'b010 && f3 != 3'b011;
		case (f3)
		3'b000: taken = a == b;
		3'b001: taken = a != b;
		3'b100: taken = $signed(a) < $signed(b);
		3'b101: taken = $signed(a) >= $signed(b);
		3'b110: taken = $signed(a) <= $signed(b);
		3'b111: taken = $signed(a) > $signed(b);
		default: taken = 1'b0;
		endcase
		res = pc + 1; // the link is the fall-through word address.
	end
	default: ok = 1'b0;
	endcase
	e = '0;
	e.rec.valid = 1'b1;
	e.rec.pc = pc;
	e.rec.rd = inst[11:7];
	e.rec.reg_write = ok && inst[6:0] != pipe_pkg::opc_branch;
	e.rec.value = res;
	e.rec.taken = taken && ok;
	e.value_known = ok;
	if (e.rec.taken)
		next_pc = pc + {{20{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8]};
	else
		next_pc = pc + 1;
	if (e.rec.reg_write && inst[11:7] != 5'd0)
		shadow_regs[inst[11:7]] = res;
endfunction

function automatic void run_model();
	expect_t e;
	logic [31:0] pc;
	logic [31:0] next_pc;
	expected.delete();
	foreach (shadow_regs[i])
		shadow_regs[i] = '0;
	pc = '0;
	while (pc < prog_len) begin // programs only branch forward.
		ref_step(rom[pc[7:0]], pc, e, next_pc);
		expected.push_back(e);
		pc = next_pc;
	end
endfunction

function automatic void put(input logic [31:0] w);
	rom[prog_len] = w;
	prog_len++;
endfunction

function automatic void put_alu(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
	logic [31:0] r;
	logic [2:0] f3;
	r = $random(seed);
	f3 = r[2:0];
	if (r[3])
		put(enc_r((f3 == 3'b000 && r[4]) ? 7'h20 : 7'h00, (f3 == 3'b011) ? 3'b000 : f3,
			rd, rs1, rs2));
	else
		put(enc_i((f3 == 3'b001 || f3 == 3'b011 || f3 == 3'b101) ? 3'b000 : f3,
			rd, rs1, r[31:20]));
endfunction

function automatic void build_prog(input int id);
	logic [31:0] r;
	logic [11:0] a;
	logic [11:0] d;
	logic [17:0] kinds;
	prog_len = 0;
	kinds = {3'b111, 3'b110, 3'b101, 3'b100, 3'b001, 3'b000};
	case (id)
	1: for (int i = 1; i < 5; i++)
		put(enc_i(3'b000, 5'(i), 5'(i - 1), 12'(3 * i)));
	2: begin
		for (int i = 1; i < 9; i++)
			put(enc_i(3'b000, 5'(i), 5'd0, 12'($random(seed))));
		for (int i = 0; i < 32; i++) begin
			r = $random(seed);
			put_alu(5'(r[3:0]), 5'(r[7:4]), 5'(r[11:8]));
		end
	end
	3: begin
		// each op reads the result still in EX and the one in writeback.
		for (int k = 0; k < 24; k++)
			put_alu(5'(k % 7 + 1), 5'((k + 6) % 7 + 1), 5'((k + 5) % 7 + 1));
		for (int k = 0; k < 3; k++)
			put(enc_i(3'b000, 5'd5, 5'd5, 12'd1));
	end
	4: for (int i = 0; i < 18; i++) begin
		r = $random(seed);
		a = {{3{r[8]}}, r[8:0]};
		d = 12'(r[15:9]) + 12'd1;
		put(enc_i(3'b000, 5'd1, 5'd0, a));
		put(enc_i(3'b000, 5'd2, 5'd0, (i % 3 == 0) ? a - d : (i % 3 == 1) ? a : a + d));
		put(enc_b(kinds[3 * (i / 3) +: 3], 5'd1, 5'd2, 12'd2));
		put(enc_i(3'b000, 5'd3, 5'd3, 12'd1)); // skipped when the branch is taken.
	end
	default: begin
		r = $random(seed);
		put(enc_i(3'b000, 5'd0, 5'd0, 12'h123));
		put(enc_r(7'h00, 3'b000, 5'd1, 5'd0, 5'd0));
		put({r[31:12], 5'd2, pipe_pkg::opc_lui});
		put({r[19:0], 5'd0, pipe_pkg::opc_lui});
		put(enc_r(7'h00, 3'b000, 5'd3, 5'd0, 5'd2));
		put(32'hffff_ffff);
		put(enc_r(7'h00, 3'b011, 5'd4, 5'd1, 5'd2)); // sltu.
		put(enc_i(3'b001, 5'd5, 5'd1, 12'd3)); // slli.
		put(enc_r(7'h01, 3'b000, 5'd6, 5'd1, 5'd2));
		put(enc_b(3'b010, 5'd1, 5'd2, 12'd2));
		put(enc_r(7'h00, 3'b000, 5'd7, 5'd4, 5'd5));
		put(enc_i(3'b000, 5'd8, 5'd0, 12'hfff));
	end
	endcase
endfunction

`endif

// ==== tests/pipe_core_tb.sv ====
`timescale 1ns/10ps

module pipe_core_tb;

	localparam int clk_period = 40;
	localparam int reset_cycles = 10;
	localparam int num_tests = 5;
	localparam int total_len = 4 + 40 + 27 + 72 + 12;
	localparam int limit_cycles = 4 * total_len + num_tests * reset_cycles;

	logic clk;
	logic rst;
	logic [pipe_pkg::xlen-1:0] fetch_pc;
	logic [pipe_pkg::xlen-1:0] fetch_inst;
	pipe_pkg::retire_t retire;

	`include "ref_model.svh"

	int errors;
	int test_errors;
	int checks;
	int bubbles; // empty retire slots since the last retired instruction.
	logic active;
	logic seen_first;
	logic prev_taken;

	pipe_core i_dut (
		.clk(clk),
		.rst(rst),
		.fetch_pc(fetch_pc),
		.fetch_inst(fetch_inst),
		.retire(retire)
	);

	always_comb begin
		if (fetch_pc < pipe_pkg::xlen'(prog_len))
			fetch_inst = rom[fetch_pc[7:0]];
		else
			fetch_inst = enc_b(3'b000, 5'd0, 5'd0, 12'd0); // parks fetch on a branch to self.
	end

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, want);
			errors++;
			test_errors++;
		end
	endtask

	always @(negedge clk) begin
		expect_t e;
		if (rst) begin
			check_field("retire.valid in reset", retire.valid, '0);
			check_field("fetch_pc in reset", fetch_pc, '0);
		end else if (active && expected.size() > 0) begin
			if (retire.valid) begin
				e = expected.pop_front();
				if (seen_first)
					check_field("bubble cycles", bubbles, prev_taken ? 1 : 0);
				check_field("pc", retire.pc, e.rec.pc);
				check_field("rd", retire.rd, e.rec.rd);
				check_field("reg_write", retire.reg_write, e.rec.reg_write);
				check_field("taken", retire.taken, e.rec.taken);
				if (e.value_known)
					check_field("value", retire.value, e.rec.value);
				seen_first = 1'b1;
				prev_taken = e.rec.taken;
				bubbles = 0;
			end else if (seen_first) begin
				bubbles++;
			end
		end
	end

	task automatic run_test(input int id, input string name);
		@(posedge clk);
		rst <= 1'b1;
		active = 1'b0;
		test_errors = 0;
		build_prog(id);
		run_model();
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		seen_first = 1'b0;
		bubbles = 0;
		active = 1'b1;
		@(negedge clk);
		check_field("fetch_pc after reset", fetch_pc, '0);
		check_field("retire.valid after reset", retire.valid, '0);
		@(negedge clk);
		check_field("retire.valid after reset", retire.valid, '0);
		@(negedge clk);
		check_field("first retire latency", retire.valid, 1'b1); // word 0 retires two cycles on.
		while (expected.size() > 0)
			@(negedge clk);
		active = 1'b0;
		$display("test %0d, %s: %s with %0d errors", id, name,
			(test_errors == 0) ? "passed" : "failed", test_errors);
	endtask

	initial begin
		#(limit_cycles * clk_period);
		$display("timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		seed = 32'h718;
		rst = 1'b1;
		active = 1'b0;
		seen_first = 1'b0;
		prev_taken = 1'b0;
		bubbles = 0;
		errors = 0;
		test_errors = 0;
		checks = 0;
		prog_len = 0;
		run_test(1, "reset state");
		run_test(2, "random alu mix");
		run_test(3, "back-to-back dependencies");
		run_test(4, "branch kinds");
		run_test(5, "x0, lui and illegal words");
		$display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
